//--- verilog.f
hdl/rv_isa_pkg.sv
hdl/hazard_pkg.sv
hdl/stage_tracker.sv
hdl/hazard_detect.sv
hdl/operand_forward.sv
hdl/stall_fsm.sv
hdl/pipeline_control.sv
sim/pipeline_control_asserts.sv
sim/pipeline_control_tb.sv

//--- Bender.yml
package:
  name: pipeline_control

sources:
  # Packages first, then RTL bottom-up
  - files:
      - hdl/rv_isa_pkg.sv
      - hdl/hazard_pkg.sv
      - hdl/stage_tracker.sv
      - hdl/hazard_detect.sv
      - hdl/operand_forward.sv
      - hdl/stall_fsm.sv
      - hdl/pipeline_control.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/pipeline_control_asserts.sv
      - sim/pipeline_control_tb.sv

//--- sim/pipeline_control_tb.sv
`timescale 1ns/100ps

module pipeline_control_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int TEST_CYCLES     = 31;    // Sum of all issue cycles below
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 20;

    logic                     clk;
    logic                     rst;
    hazard_pkg::decode_info_t decode;
    hazard_pkg::operands_t    dec_operands;
    hazard_pkg::result_taps_t taps;
    hazard_pkg::operands_t    fwd_operands;
    logic                     f_to_d_enable;
    logic                     d_to_e_enable;
    logic [31:0]              lcg_state;

    pipeline_control dut_i (
        .clk           (clk),
        .rst           (rst),
        .decode        (decode),
        .dec_operands  (dec_operands),
        .taps          (taps),
        .fwd_operands  (fwd_operands),
        .f_to_d_enable (f_to_d_enable),
        .d_to_e_enable (d_to_e_enable)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Two LCG steps make one 64-bit data word
    function automatic rv_isa_pkg::xword_t lcg_word();
        logic [31:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state};
    endfunction

    task automatic report_fail();
        $display("STATUS: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::xword_t exp,
                              input rv_isa_pkg::xword_t act);
        assert (act === exp) else begin
            $display("** Error: %s expected %h, actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_operands(input hazard_pkg::operands_t exp);
        check_word("fwd_operands.alu_a", exp.alu_a, fwd_operands.alu_a);
        check_word("fwd_operands.alu_b", exp.alu_b, fwd_operands.alu_b);
        check_word("fwd_operands.br_rs1", exp.br_rs1, fwd_operands.br_rs1);
        check_word("fwd_operands.br_rs2", exp.br_rs2, fwd_operands.br_rs2);
        check_word("fwd_operands.jump_base", exp.jump_base, fwd_operands.jump_base);
        check_word("fwd_operands.store_data", exp.store_data, fwd_operands.store_data);
    endtask

    task automatic check_enables(input logic exp_f, input logic exp_d);
        assert (f_to_d_enable === exp_f) else begin
            $display("** Error: f_to_d_enable expected %h, actual %h", exp_f, f_to_d_enable);
            report_fail();
        end
        assert (d_to_e_enable === exp_d) else begin
            $display("** Error: d_to_e_enable expected %h, actual %h", exp_d, d_to_e_enable);
            report_fail();
        end
    endtask

    // Present one instruction with fresh data, return mid-cycle for checks
    task automatic issue(input rv_isa_pkg::opcode_e op, input rv_isa_pkg::reg_idx_t rd,
                         input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::reg_idx_t rs2);
        @(posedge clk);
        #2;
        decode.opcode = op;
        decode.rd     = rd;
        decode.rs1    = rs1;
        decode.rs2    = rs2;
        dec_operands.alu_a      = lcg_word();
        dec_operands.alu_b      = lcg_word();
        dec_operands.br_rs1     = lcg_word();
        dec_operands.br_rs2     = lcg_word();
        dec_operands.jump_base  = lcg_word();
        dec_operands.store_data = lcg_word();
        taps.ex_alu  = lcg_word();
        taps.mem_alu = lcg_word();
        taps.mem_dm  = lcg_word();
        @(negedge clk);
    endtask

    // Two idle instructions push older producers out of both slots
    task automatic flush();
        repeat (2) issue(rv_isa_pkg::OP_OP_IMM, 5'd0, 5'd0, 5'd0);
    endtask

    task automatic test_after_reset();
        check_enables(1'b1, 1'b1);
        issue(rv_isa_pkg::OP_OP, 5'd5, 5'd7, 5'd9);
        check_operands(dec_operands);
    endtask

    task automatic test_alu_forwarding();
        hazard_pkg::operands_t exp;
        flush();
        issue(rv_isa_pkg::OP_OP, 5'd10, 5'd1, 5'd2);
        check_operands(dec_operands);
        issue(rv_isa_pkg::OP_OP, 5'd11, 5'd10, 5'd10);   // Reads x10 from execute
        exp = dec_operands;
        exp.alu_a     = taps.ex_alu;
        exp.jump_base = taps.ex_alu;
        exp.alu_b     = taps.ex_alu;
        exp.br_rs2    = taps.ex_alu;
        check_operands(exp);
        issue(rv_isa_pkg::OP_OP_IMM, 5'd12, 5'd3, 5'd4);
        check_operands(dec_operands);
        issue(rv_isa_pkg::OP_OP, 5'd13, 5'd11, 5'd11);   // x11 now in memory stage
        exp = dec_operands;
        exp.alu_a     = taps.mem_alu;
        exp.jump_base = taps.mem_alu;
        exp.alu_b     = taps.mem_alu;
        exp.br_rs2    = taps.mem_alu;
        check_operands(exp);
        issue(rv_isa_pkg::OP_OP, 5'd20, 5'd0, 5'd0);
        issue(rv_isa_pkg::OP_OP, 5'd20, 5'd0, 5'd0);
        check_operands(dec_operands);
        issue(rv_isa_pkg::OP_OP, 5'd21, 5'd20, 5'd20);   // Newer x20 must win
        exp = dec_operands;
        exp.alu_a     = taps.ex_alu;
        exp.jump_base = taps.ex_alu;
        exp.alu_b     = taps.ex_alu;
        exp.br_rs2    = taps.ex_alu;
        check_operands(exp);
    endtask

    task automatic test_load_use();
        hazard_pkg::operands_t exp;
        flush();
        issue(rv_isa_pkg::OP_LOAD, 5'd8, 5'd2, 5'd0);
        check_enables(1'b1, 1'b1);
        issue(rv_isa_pkg::OP_OP, 5'd9, 5'd8, 5'd3);      // Needs the load result
        check_operands(dec_operands);
        check_enables(1'b1, 1'b1);
        issue(rv_isa_pkg::OP_OP, 5'd9, 5'd8, 5'd3);      // Held instruction again
        check_enables(1'b0, 1'b0);
        exp = dec_operands;
        exp.alu_a     = taps.mem_dm;
        exp.jump_base = taps.mem_dm;
        check_operands(exp);
        issue(rv_isa_pkg::OP_OP, 5'd9, 5'd8, 5'd3);
        check_enables(1'b0, 1'b1);
        issue(rv_isa_pkg::OP_OP_IMM, 5'd0, 5'd0, 5'd0);
        check_enables(1'b1, 1'b1);
    endtask

    task automatic test_routing();
        hazard_pkg::operands_t exp;
        flush();
        issue(rv_isa_pkg::OP_OP, 5'd14, 5'd0, 5'd0);
        issue(rv_isa_pkg::OP_BRANCH, 5'h1f, 5'd14, 5'd0);
        exp = dec_operands;
        exp.alu_a  = taps.ex_alu;
        exp.br_rs1 = taps.ex_alu;
        check_operands(exp);
        issue(rv_isa_pkg::OP_OP, 5'd15, 5'd0, 5'd0);
        issue(rv_isa_pkg::OP_JALR, 5'd1, 5'd15, 5'd0);
        exp = dec_operands;
        exp.alu_a     = taps.ex_alu;
        exp.jump_base = taps.ex_alu;
        check_operands(exp);
        issue(rv_isa_pkg::OP_OP, 5'd16, 5'd0, 5'd0);
        issue(rv_isa_pkg::OP_STORE, 5'h0a, 5'd3, 5'd16);
        exp = dec_operands;
        exp.br_rs2     = taps.ex_alu;
        exp.store_data = taps.ex_alu;
        check_operands(exp);
    endtask

    task automatic test_zero_register();
        flush();
        issue(rv_isa_pkg::OP_LOAD, 5'd0, 5'd0, 5'd0);
        issue(rv_isa_pkg::OP_OP, 5'd6, 5'd0, 5'd0);
        check_operands(dec_operands);
        check_enables(1'b1, 1'b1);
        issue(rv_isa_pkg::OP_OP, 5'd0, 5'd3, 5'd4);
        check_operands(dec_operands);
        check_enables(1'b1, 1'b1);                      // No stall from the x0 load
        issue(rv_isa_pkg::OP_OP, 5'd7, 5'd0, 5'd0);
        check_operands(dec_operands);
        check_enables(1'b1, 1'b1);
    endtask

    // Watch the bound stall checks
    always @(negedge clk) begin
        assert (dut_i.stall_fsm_i.stall_fsm_asserts_i.error_count == 0) else begin
            $display("A bound stall assertion failed, see the error above");
            report_fail();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        report_fail();
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        lcg_state    = 32'h8fb3;
        decode.opcode = rv_isa_pkg::OP_OP_IMM;
        decode.rd     = '0;
        decode.rs1    = '0;
        decode.rs2    = '0;
        dec_operands  = '0;
        taps          = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        test_after_reset();
        test_alu_forwarding();
        test_load_use();
        test_routing();
        test_zero_register();
        if (dut_i.stall_fsm_i.stall_fsm_asserts_i.error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("A bound stall assertion failed, see the error above");
            report_fail();
        end
    end

endmodule

//--- sim/pipeline_control_asserts.sv
`timescale 1ns/100ps

module stall_fsm_asserts (
    input logic clk,
    input logic rst,
    input logic f_to_d_enable,
    input logic d_to_e_enable
);

    int error_count = 0;    // Failed assertions so far

    // Decode is only held together with fetch
    property decode_hold_with_fetch;
        @(posedge clk) disable iff (rst)
            !(f_to_d_enable && !d_to_e_enable);
    endproperty

    // Second stall cycle releases decode but still holds fetch
    property hold_sequence;
        @(posedge clk) disable iff (rst)
            !d_to_e_enable |=> (d_to_e_enable && !f_to_d_enable);
    endproperty

    property run_after_reset;
        @(posedge clk) $fell(rst) |-> (f_to_d_enable && d_to_e_enable);
    endproperty

    assert property (decode_hold_with_fetch) else begin
        $error("d_to_e_enable low while f_to_d_enable high");
        error_count++;
    end
    assert property (hold_sequence) else begin
        $error("Stall did not continue with fetch held and decode released");
        error_count++;
    end
    assert property (run_after_reset) else begin
        $error("Enables not both high in the first cycle after reset");
        error_count++;
    end

endmodule

bind stall_fsm stall_fsm_asserts stall_fsm_asserts_i (
    .clk           (clk),
    .rst           (rst),
    .f_to_d_enable (f_to_d_enable),
    .d_to_e_enable (d_to_e_enable)
);

//--- hdl/pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control (
    input  logic                     clk,
    input  logic                     rst,
    input  hazard_pkg::decode_info_t decode,
    input  hazard_pkg::operands_t    dec_operands,
    input  hazard_pkg::result_taps_t taps,
    output hazard_pkg::operands_t    fwd_operands,
    output logic                     f_to_d_enable,
    output logic                     d_to_e_enable
);

    hazard_pkg::slot_info_t ex_slot;    // Instruction in execute
    hazard_pkg::slot_info_t mem_slot;   // Instruction in memory access
    hazard_pkg::fwd_sel_t   fwd_sel;
    logic                   load_use_hit;

    stage_tracker stage_tracker_i (
        .clk           (clk),
        .rst           (rst),
        .decode        (decode),
        .d_to_e_enable (d_to_e_enable),
        .ex_slot       (ex_slot),
        .mem_slot      (mem_slot)
    );

    hazard_detect hazard_detect_i (
        .decode       (decode),
        .ex_slot      (ex_slot),
        .mem_slot     (mem_slot),
        .fwd_sel      (fwd_sel),
        .load_use_hit (load_use_hit)
    );

    // Same-cycle path from decode and taps to the forwarded operands
    operand_forward operand_forward_i (
        .decode       (decode),
        .fwd_sel      (fwd_sel),
        .dec_operands (dec_operands),
        .taps         (taps),
        .fwd_operands (fwd_operands)
    );

    stall_fsm stall_fsm_i (
        .clk           (clk),
        .rst           (rst),
        .load_use_hit  (load_use_hit),
        .f_to_d_enable (f_to_d_enable),
        .d_to_e_enable (d_to_e_enable)
    );

endmodule

//--- hdl/stall_fsm.sv
`timescale 1ns/100ps

module stall_fsm (
    input  logic clk,
    input  logic rst,
    input  logic load_use_hit,
    output logic f_to_d_enable,
    output logic d_to_e_enable
);

    hazard_pkg::stall_state_e state;
    hazard_pkg::stall_state_e state_next;

    // Two cycles of stall, counted out by the hold states
    always_comb begin
        state_next = state;
        case (state)
            hazard_pkg::ST_RUN: begin
                if (load_use_hit) begin
                    state_next = hazard_pkg::ST_HOLD_DECODE;
                end
            end
            hazard_pkg::ST_HOLD_DECODE: begin
                state_next = hazard_pkg::ST_HOLD_FETCH;
            end
            hazard_pkg::ST_HOLD_FETCH: begin
                state_next = hazard_pkg::ST_RUN;
            end
            default: begin
                state_next = hazard_pkg::ST_RUN;
            end
        endcase
    end

    // Enables are decoded from the next state and registered,
    // so they line up with the state during the cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= hazard_pkg::ST_RUN;
            f_to_d_enable <= 1'b1;
            d_to_e_enable <= 1'b1;
        end else begin
            state         <= state_next;
            f_to_d_enable <= (state_next == hazard_pkg::ST_RUN);
            d_to_e_enable <= (state_next != hazard_pkg::ST_HOLD_DECODE);
        end
    end

endmodule

//--- hdl/operand_forward.sv
`timescale 1ns/100ps

module operand_forward (
    input  hazard_pkg::decode_info_t decode,
    input  hazard_pkg::fwd_sel_t     fwd_sel,
    input  hazard_pkg::operands_t    dec_operands,
    input  hazard_pkg::result_taps_t taps,
    output hazard_pkg::operands_t    fwd_operands
);

    rv_isa_pkg::xword_t word_a;     // Forwarded value for rs1
    rv_isa_pkg::xword_t word_b;     // Forwarded value for rs2
    logic               fwd_a;
    logic               fwd_b;
    logic               is_branch;
    logic               is_store;

    // Result tap picked by a forward select
    function automatic rv_isa_pkg::xword_t tap_word(
        input hazard_pkg::fwd_src_e     sel,
        input hazard_pkg::result_taps_t t
    );
        case (sel)
            hazard_pkg::FWD_EX_ALU: begin
                return t.ex_alu;
            end
            hazard_pkg::FWD_MEM_ALU: begin
                return t.mem_alu;
            end
            hazard_pkg::FWD_MEM_DM: begin
                return t.mem_dm;
            end
            default: begin
                return '0;              // Unused, the decoder value is kept
            end
        endcase
    endfunction

    assign word_a = tap_word(fwd_sel.sel_a, taps);
    assign word_b = tap_word(fwd_sel.sel_b, taps);

    assign fwd_a = (fwd_sel.sel_a != hazard_pkg::FWD_RF);
    assign fwd_b = (fwd_sel.sel_b != hazard_pkg::FWD_RF);

    assign is_branch = (decode.opcode == rv_isa_pkg::OP_BRANCH);
    assign is_store  = (decode.opcode == rv_isa_pkg::OP_STORE);

    // Route each forwarded word to the consumers that read it
    always_comb begin
        fwd_operands = dec_operands;

        if (fwd_a) begin
            fwd_operands.alu_a = word_a;
            if (is_branch) begin
                fwd_operands.br_rs1 = word_a;       // Comparator input
            end else begin
                fwd_operands.jump_base = word_a;    // JALR target base
            end
        end

        if (fwd_b) begin
            fwd_operands.br_rs2 = word_b;
            // Store ALU computes the address from rs1 plus immediate
            if (is_store) begin
                fwd_operands.store_data = word_b;
            end else begin
                fwd_operands.alu_b = word_b;
            end
        end
    end

endmodule

//--- hdl/hazard_detect.sv
`timescale 1ns/100ps

module hazard_detect (
    input  hazard_pkg::decode_info_t decode,
    input  hazard_pkg::slot_info_t   ex_slot,
    input  hazard_pkg::slot_info_t   mem_slot,
    output hazard_pkg::fwd_sel_t     fwd_sel,
    output logic                     load_use_hit
);

    logic uses_rs1;
    logic uses_rs2;
    logic ex_match_a;
    logic ex_match_b;
    logic mem_match_a;
    logic mem_match_b;

    // Newest producer first, a load in execute has nothing to give yet
    function automatic hazard_pkg::fwd_src_e pick_src(
        input logic ex_match,
        input logic ex_load,
        input logic mem_match,
        input logic mem_load
    );
        if (ex_match) begin
            return ex_load ? hazard_pkg::FWD_RF : hazard_pkg::FWD_EX_ALU;
        end
        if (mem_match) begin
            return mem_load ? hazard_pkg::FWD_MEM_DM : hazard_pkg::FWD_MEM_ALU;
        end
        return hazard_pkg::FWD_RF;
    endfunction

    // Which source fields are real register reads for this opcode
    always_comb begin
        case (decode.opcode)
            rv_isa_pkg::OP_OP,
            rv_isa_pkg::OP_STORE,
            rv_isa_pkg::OP_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            rv_isa_pkg::OP_OP_IMM,
            rv_isa_pkg::OP_LOAD,
            rv_isa_pkg::OP_JALR: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b0;
            end
            default: begin              // LUI, AUIPC, JAL
                uses_rs1 = 1'b0;
                uses_rs2 = 1'b0;
            end
        endcase
    end

    // x0 is excluded on the reader side, which also covers rd x0 producers
    assign ex_match_a  = uses_rs1 && (decode.rs1 != rv_isa_pkg::REG_ZERO)
                         && (decode.rs1 == ex_slot.rd);
    assign ex_match_b  = uses_rs2 && (decode.rs2 != rv_isa_pkg::REG_ZERO)
                         && (decode.rs2 == ex_slot.rd);
    assign mem_match_a = uses_rs1 && (decode.rs1 != rv_isa_pkg::REG_ZERO)
                         && (decode.rs1 == mem_slot.rd);
    assign mem_match_b = uses_rs2 && (decode.rs2 != rv_isa_pkg::REG_ZERO)
                         && (decode.rs2 == mem_slot.rd);

    always_comb begin
        fwd_sel.sel_a = pick_src(ex_match_a, ex_slot.is_load,
                                 mem_match_a, mem_slot.is_load);
        fwd_sel.sel_b = pick_src(ex_match_b, ex_slot.is_load,
                                 mem_match_b, mem_slot.is_load);
    end

    // Load data only exists once the load reaches memory
    assign load_use_hit = ex_slot.is_load && (ex_match_a || ex_match_b);

endmodule

//--- hdl/stage_tracker.sv
`timescale 1ns/100ps

module stage_tracker (
    input  logic                     clk,
    input  logic                     rst,
    input  hazard_pkg::decode_info_t decode,
    input  logic                     d_to_e_enable,
    output hazard_pkg::slot_info_t   ex_slot,
    output hazard_pkg::slot_info_t   mem_slot
);

    logic                   writes_rd;
    hazard_pkg::slot_info_t dec_slot;   // Decode instruction in slot form

    // Only real register writers may be tracked as producers
    always_comb begin
        case (decode.opcode)
            rv_isa_pkg::OP_STORE,
            rv_isa_pkg::OP_BRANCH: begin
                writes_rd = 1'b0;       // rd field holds immediate bits
            end
            default: begin
                writes_rd = 1'b1;
            end
        endcase
    end

    always_comb begin
        dec_slot = hazard_pkg::SLOT_BUBBLE;
        if (writes_rd) begin
            dec_slot.rd = decode.rd;
        end
        dec_slot.is_load = (decode.opcode == rv_isa_pkg::OP_LOAD);
    end

    // Two-deep history of execute and memory occupants.
    // A held decode stage sends a bubble into execute, so the
    // older instruction walks on to memory without a twin behind it.
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_slot  <= hazard_pkg::SLOT_BUBBLE;
            mem_slot <= hazard_pkg::SLOT_BUBBLE;
        end else begin
            mem_slot <= ex_slot;
            if (d_to_e_enable) begin
                ex_slot <= dec_slot;
            end else begin
                ex_slot <= hazard_pkg::SLOT_BUBBLE;   // Insert bubble
            end
        end
    end

endmodule

//--- hdl/hazard_pkg.sv
package hazard_pkg;

    // Where a decode operand comes from
    typedef enum logic [1:0] {
        FWD_RF      = 2'd0,     // Register file value from the decoder
        FWD_EX_ALU  = 2'd1,     // ALU result of the instruction in execute
        FWD_MEM_ALU = 2'd2,     // ALU result bypassed from memory stage
        FWD_MEM_DM  = 2'd3      // Data memory read data
    } fwd_src_e;

    // Load-use stall sequence
    typedef enum logic [1:0] {
        ST_RUN         = 2'd0,
        ST_HOLD_DECODE = 2'd1,  // Fetch and decode both frozen
        ST_HOLD_FETCH  = 2'd2   // Only fetch frozen
    } stall_state_e;

    // Register fields of the instruction in decode
    typedef struct packed {
        rv_isa_pkg::opcode_e  opcode;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
    } decode_info_t;

    // What an older instruction still owes the pipeline
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rd;
        logic                 is_load;
    } slot_info_t;

    localparam slot_info_t SLOT_BUBBLE = '0;  // rd x0, not a load

    typedef struct packed {
        fwd_src_e sel_a;
        fwd_src_e sel_b;
    } fwd_sel_t;

    typedef struct packed {
        rv_isa_pkg::xword_t alu_a;
        rv_isa_pkg::xword_t alu_b;
        rv_isa_pkg::xword_t br_rs1;
        rv_isa_pkg::xword_t br_rs2;
        rv_isa_pkg::xword_t jump_base;
        rv_isa_pkg::xword_t store_data;
    } operands_t;

    // Results available from the later stages this cycle
    typedef struct packed {
        rv_isa_pkg::xword_t ex_alu;
        rv_isa_pkg::xword_t mem_alu;
        rv_isa_pkg::xword_t mem_dm;
    } result_taps_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN      = 64;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;

    // Architectural register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // x0 always reads as zero and never carries a dependency
    localparam reg_idx_t REG_ZERO = '0;

    // One integer data word
    typedef logic [XLEN-1:0] xword_t;

    // Major opcode, instruction bits 6:0
    typedef enum logic [OPCODE_W-1:0] {
        OP_LOAD   = 7'b0000011,
        OP_OP_IMM = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Stores and branches reuse the rd field for immediate bits,
    // LUI, AUIPC and JAL reuse the rs fields the same way.
    // The users of these types mask those fields by opcode.

endpackage
